/* Makefile */
TOP := tb_iram

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build and run the testbench with Verilator"
	@echo "  clean  remove the build directory"

test:
	verilator --binary --timing --assert --top-module $(TOP) -f project.f -Mdir obj_dir
	./obj_dir/V$(TOP)

clean:
	rm -rf obj_dir

/* project.f */
rtl/iram_pkg.sv
rtl/fetch_unit.sv
rtl/inst_ram.sv
rtl/inst_decoder.sv
rtl/iram_top.sv
sim/tb_clock.sv
sim/tb_iram.sv

/* rtl/fetch_unit.sv */
`default_nettype none

module fetch_unit (
  input  logic                          clk,
  input  logic                          nrst,
  input  logic                          run,
  input  logic                          host_wr,
  input  logic [iram_pkg::BADDR_W-1:0]  host_addr,
  input  logic [iram_pkg::NBYTES-1:0]   host_wstrb,
  input  logic [iram_pkg::XLEN-1:0]     host_wdata,
  output iram_pkg::bus_req_t            ram_req
);

  typedef enum logic {
    FETCH_IDLE,
    FETCH_RUN
  } fetch_state_e;

  fetch_state_e                   state;
  logic [iram_pkg::BADDR_W-1:0]   pc;

  // Pending host write
  logic                           wr_pend;
  logic [iram_pkg::BADDR_W-1:0]   wr_addr;
  logic [iram_pkg::NBYTES-1:0]    wr_wstrb;
  logic [iram_pkg::XLEN-1:0]      wr_wdata;

  always_ff @(posedge clk) begin
    if (!nrst) begin
      state   <= FETCH_IDLE;
      pc      <= '0;
      wr_pend <= 1'b0;
    end else begin
      wr_pend <= host_wr;
      case (state)
        FETCH_IDLE: if (run) state <= FETCH_RUN;
        FETCH_RUN: begin
          // Write owns the bus this cycle, hold pc
          if (!wr_pend) pc <= pc + iram_pkg::PC_STEP;
          if (!run) state <= FETCH_IDLE;
        end
        default: state <= FETCH_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (host_wr) begin
      wr_addr  <= host_addr;
      wr_wstrb <= host_wstrb;
      wr_wdata <= host_wdata;
    end
  end

  always_comb begin
    ram_req = '0;
    if (wr_pend) begin
      ram_req.req   = 1'b1;
      ram_req.addr  = wr_addr;
      ram_req.wstrb = wr_wstrb;
      ram_req.wdata = wr_wdata;
    end else if (state == FETCH_RUN) begin
      ram_req.req  = 1'b1;
      ram_req.addr = pc;
    end
  end

endmodule

`default_nettype wire

/* rtl/inst_decoder.sv */
`default_nettype none

module inst_decoder (
  input  logic                clk,
  input  logic                nrst,
  input  iram_pkg::bus_rsp_t  ram_rsp,
  output iram_pkg::dec_t      dec
);

  logic [iram_pkg::XLEN-1:0]     word;
  logic [6:0]                    major;
  iram_pkg::opcode_e             op_d;
  logic [4:0]                    rd_d;
  logic [iram_pkg::XLEN-1:0]     imm_d;

  logic                          valid_q;
  logic [iram_pkg::BADDR_W-1:0]  addr_q;
  iram_pkg::opcode_e             op_q;
  logic [4:0]                    rd_q;
  logic [iram_pkg::XLEN-1:0]     imm_q;

  assign word  = ram_rsp.rdata;
  assign major = word[6:0];
  assign rd_d  = word[11:7];

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Opcode class and immediate per format
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  always_comb begin
    op_d  = iram_pkg::OP_OTHER;
    imm_d = '0;
    case (major)
      iram_pkg::MAJ_LUI: begin
        op_d  = iram_pkg::OP_LUI;
        imm_d = {word[31:12], 12'd0};
      end
      iram_pkg::MAJ_LOAD: begin
        op_d  = iram_pkg::OP_LOAD;
        imm_d = {{20{word[31]}}, word[31:20]};
      end
      iram_pkg::MAJ_IMM: begin
        op_d  = iram_pkg::OP_IMM;
        imm_d = {{20{word[31]}}, word[31:20]};
      end
      iram_pkg::MAJ_STORE: begin
        op_d  = iram_pkg::OP_STORE;
        imm_d = {{20{word[31]}}, word[31:25], word[11:7]};
      end
      iram_pkg::MAJ_JAL: begin
        // J-type scatter
        op_d  = iram_pkg::OP_JAL;
        imm_d = {{12{word[31]}}, word[19:12], word[20], word[30:21], 1'b0};
      end
      default: ;
    endcase
  end

  always_ff @(posedge clk) begin
    if (!nrst) begin
      valid_q <= 1'b0;
    end else begin
      valid_q <= ram_rsp.data_gnt;
    end
  end

  always_ff @(posedge clk) begin
    if (ram_rsp.data_gnt) begin
      addr_q <= ram_rsp.addr;
      op_q   <= op_d;
      rd_q   <= rd_d;
      imm_q  <= imm_d;
    end
  end

  assign dec.valid = valid_q;
  assign dec.addr  = addr_q;
  assign dec.op    = op_q;
  assign dec.rd    = rd_q;
  assign dec.imm   = imm_q;

endmodule

`default_nettype wire

/* rtl/inst_ram.sv */
`default_nettype none

module inst_ram (
  input  logic                clk,
  input  logic                nrst,
  input  iram_pkg::bus_req_t  ram_req,
  output iram_pkg::bus_rsp_t  ram_rsp
);

  iram_pkg::image_t                mem;
  logic [iram_pkg::ADDR_W-1:0]     word_idx;
  logic                            is_write;
  logic                            is_read;

  logic                            gnt_q;
  logic [iram_pkg::BADDR_W-1:0]    addr_q;
  logic [iram_pkg::XLEN-1:0]       rdata_q;

  assign word_idx = ram_req.addr[iram_pkg::ADDR_W+1:2];
  assign is_write = ram_req.req && (|ram_req.wstrb);
  assign is_read  = ram_req.req && !(|ram_req.wstrb);

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Array with reset preload and byte writes
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  always_ff @(posedge clk) begin
    if (!nrst) begin
      mem <= iram_pkg::reset_image();
    end else if (is_write) begin
      for (int i = 0; i < iram_pkg::NBYTES; i++) begin
        if (ram_req.wstrb[i]) mem[word_idx][8*i +: 8] <= ram_req.wdata[8*i +: 8];
      end
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Read port, one cycle
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  always_ff @(posedge clk) begin
    if (!nrst) begin
      gnt_q <= 1'b0;
    end else begin
      gnt_q <= is_read;
    end
  end

  always_ff @(posedge clk) begin
    if (is_read) begin
      rdata_q <= mem[word_idx];
      addr_q  <= ram_req.addr;
    end
  end

  assign ram_rsp.data_gnt = gnt_q;
  assign ram_rsp.addr     = addr_q;
  assign ram_rsp.rdata    = rdata_q;

endmodule

`default_nettype wire

/* rtl/iram_pkg.sv */
`default_nettype none

package iram_pkg;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Sizes
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  localparam int XLEN    = 32;
  localparam int ADDR_W  = 4;
  localparam int BADDR_W = ADDR_W + 2;
  localparam int WORDS   = 2 ** ADDR_W;
  localparam int NBYTES  = XLEN / 8;

  localparam logic [BADDR_W-1:0] PC_STEP = BADDR_W'(4);

  // Major opcodes
  localparam logic [6:0] MAJ_LUI   = 7'b0110111;
  localparam logic [6:0] MAJ_LOAD  = 7'b0000011;
  localparam logic [6:0] MAJ_STORE = 7'b0100011;
  localparam logic [6:0] MAJ_JAL   = 7'b1101111;
  localparam logic [6:0] MAJ_IMM   = 7'b0010011;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Bus and decode types
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  typedef struct packed {
    logic                req;
    logic [BADDR_W-1:0]  addr;
    logic [NBYTES-1:0]   wstrb;
    logic [XLEN-1:0]     wdata;
  } bus_req_t;

  typedef struct packed {
    logic                data_gnt;
    logic [BADDR_W-1:0]  addr;
    logic [XLEN-1:0]     rdata;
  } bus_rsp_t;

  typedef enum logic [2:0] {
    OP_LUI,
    OP_LOAD,
    OP_STORE,
    OP_JAL,
    OP_IMM,
    OP_OTHER
  } opcode_e;

  typedef struct packed {
    logic                valid;
    logic [BADDR_W-1:0]  addr;
    opcode_e             op;
    logic [4:0]          rd;
    logic [XLEN-1:0]     imm;
  } dec_t;

  typedef logic [WORDS-1:0][XLEN-1:0] image_t;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Instruction encoders
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  function automatic logic [XLEN-1:0] enc_lui(logic [4:0] rd, logic [19:0] imm);
    return {imm, rd, MAJ_LUI};
  endfunction

  function automatic logic [XLEN-1:0] enc_lb(logic [4:0] rd, logic [11:0] imm,
                                             logic [4:0] rs1);
    return {imm, rs1, 3'b000, rd, MAJ_LOAD};
  endfunction

  function automatic logic [XLEN-1:0] enc_sb(logic [4:0] rs2, logic [11:0] imm,
                                             logic [4:0] rs1);
    return {imm[11:5], rs2, rs1, 3'b000, imm[4:0], MAJ_STORE};
  endfunction

  // addi x0, x0, 0
  function automatic logic [XLEN-1:0] enc_nop();
    return {12'd0, 5'd0, 3'b000, 5'd0, MAJ_IMM};
  endfunction

  // Byte offset, bit 0 dropped
  function automatic logic [XLEN-1:0] enc_jal(logic [4:0] rd, logic [20:0] off);
    return {off[20], off[10:1], off[11], off[19:12], rd, MAJ_JAL};
  endfunction

  function automatic image_t reset_image();
    image_t img;
    for (int i = 0; i < WORDS; i++) begin
      img[i] = enc_nop();
    end
    img[0] = enc_lui(5'd1, 20'hD0010);
    img[1] = enc_lb(5'd2, 12'h001, 5'd1);
    img[2] = enc_lui(5'd1, 20'hF0000);
    img[3] = enc_sb(5'd2, 12'h000, 5'd1);
    img[4] = enc_nop();
    img[5] = enc_jal(5'd0, -21'sd4);
    return img;
  endfunction

endpackage

`default_nettype wire

/* rtl/iram_top.sv */
`default_nettype none

module iram_top (
  input  logic                          clk,
  input  logic                          nrst,
  input  logic                          run,
  input  logic                          host_wr,
  input  logic [iram_pkg::BADDR_W-1:0]  host_addr,
  input  logic [iram_pkg::NBYTES-1:0]   host_wstrb,
  input  logic [iram_pkg::XLEN-1:0]     host_wdata,
  output iram_pkg::dec_t                dec
);

  iram_pkg::bus_req_t  ram_req;
  iram_pkg::bus_rsp_t  ram_rsp;

  // Fetch and host write merge
  fetch_unit u_fetch (
    .clk        (clk),
    .nrst       (nrst),
    .run        (run),
    .host_wr    (host_wr),
    .host_addr  (host_addr),
    .host_wstrb (host_wstrb),
    .host_wdata (host_wdata),
    .ram_req    (ram_req)
  );

  // Instruction store
  inst_ram u_ram (
    .clk     (clk),
    .nrst    (nrst),
    .ram_req (ram_req),
    .ram_rsp (ram_rsp)
  );

  // Returned words to decoded fields
  inst_decoder u_dec (
    .clk     (clk),
    .nrst    (nrst),
    .ram_rsp (ram_rsp),
    .dec     (dec)
  );

endmodule

`default_nettype wire

/* sim/tb_clock.sv */
`default_nettype none

module tb_clock (
  output logic clk,
  output logic nrst
);
  timeunit 1ns;
  timeprecision 1ps;

  // 20 ns period
  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  // Held low for 16 rising edges, released just after the last one
  initial begin
    nrst = 1'b0;
    repeat (16) @(posedge clk);
    #2;
    nrst = 1'b1;
  end

endmodule

`default_nettype wire

/* sim/tb_iram.sv */
`default_nettype none

module tb_iram;
  timeunit 1ns;
  timeprecision 1ps;

  typedef struct packed {
    logic [31:0]                   at_edge;
    logic [iram_pkg::BADDR_W-1:0]  addr;
    logic [iram_pkg::NBYTES-1:0]   strb;
    logic [iram_pkg::XLEN-1:0]     data;
  } host_write_t;

  logic                          clk;
  logic                          nrst;
  logic                          run;
  logic                          host_wr;
  logic [iram_pkg::BADDR_W-1:0]  host_addr;
  logic [iram_pkg::NBYTES-1:0]   host_wstrb;
  logic [iram_pkg::XLEN-1:0]     host_wdata;
  iram_pkg::dec_t                dec;

  iram_pkg::image_t              model_mem;
  iram_pkg::image_t              boot_mem;
  host_write_t                   pending[$];
  logic [31:0]                   edge_cnt;
  int unsigned                   resp_cnt;
  logic [iram_pkg::BADDR_W-1:0]  next_addr;
  logic                          idle_window;
  int unsigned                   other_cnt;
  int unsigned                   patched_cnt;

  tb_clock u_clock (.clk(clk), .nrst(nrst));

  iram_top u_dut (
    .clk        (clk),
    .nrst       (nrst),
    .run        (run),
    .host_wr    (host_wr),
    .host_addr  (host_addr),
    .host_wstrb (host_wstrb),
    .host_wdata (host_wdata),
    .dec        (dec)
  );

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Reference decoding
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  function automatic iram_pkg::opcode_e ref_op(logic [31:0] word);
    case (word[6:0])
      7'h37:   return iram_pkg::OP_LUI;
      7'h03:   return iram_pkg::OP_LOAD;
      7'h23:   return iram_pkg::OP_STORE;
      7'h6f:   return iram_pkg::OP_JAL;
      7'h13:   return iram_pkg::OP_IMM;
      default: return iram_pkg::OP_OTHER;
    endcase
  endfunction

  function automatic logic [31:0] ref_imm(logic [31:0] word);
    logic [20:0] joff;
    joff = {word[31], word[19:12], word[20], word[30:21], 1'b0};
    case (ref_op(word))
      iram_pkg::OP_LUI:   return word & 32'hFFFF_F000;
      iram_pkg::OP_LOAD:  return 32'($signed(word) >>> 20);
      iram_pkg::OP_IMM:   return 32'($signed(word) >>> 20);
      iram_pkg::OP_STORE: return (32'($signed(word) >>> 25) << 5) | {27'd0, word[11:7]};
      iram_pkg::OP_JAL:   return {{11{joff[20]}}, joff};
      default:            return 32'd0;
    endcase
  endfunction

  function automatic logic [31:0] merge_bytes(logic [31:0] old, logic [31:0] data,
                                              logic [3:0] strb);
    logic [31:0] mask;
    mask = {{8{strb[3]}}, {8{strb[2]}}, {8{strb[1]}}, {8{strb[0]}}};
    return (old & ~mask) | (data & mask);
  endfunction

  task automatic stop_fail(string what);
    $display("%s", what);
    $display("=== FAIL ===");
    $fatal(1, "simulation stopped");
  endtask

  task automatic check_field(string sig, logic [31:0] exp, logic [31:0] act);
    assert (act === exp)
    else stop_fail($sformatf("** Error: %s expected 0x%08h actual 0x%08h", sig, exp, act));
  endtask

  // Fixed fields of the boot program
  task automatic check_boot_word();
    case (dec.addr[5:2])
      4'd0: begin
        check_field("dec.op", 32'(iram_pkg::OP_LUI), 32'(dec.op));
        check_field("dec.rd", 32'd1, 32'(dec.rd));
        check_field("dec.imm", 32'hD001_0000, dec.imm);
      end
      4'd1: begin
        check_field("dec.op", 32'(iram_pkg::OP_LOAD), 32'(dec.op));
        check_field("dec.rd", 32'd2, 32'(dec.rd));
        check_field("dec.imm", 32'd1, dec.imm);
      end
      4'd2: begin
        check_field("dec.op", 32'(iram_pkg::OP_LUI), 32'(dec.op));
        check_field("dec.rd", 32'd1, 32'(dec.rd));
        check_field("dec.imm", 32'hF000_0000, dec.imm);
      end
      4'd3: begin
        check_field("dec.op", 32'(iram_pkg::OP_STORE), 32'(dec.op));
        check_field("dec.imm", 32'd0, dec.imm);
      end
      4'd5: begin
        check_field("dec.op", 32'(iram_pkg::OP_JAL), 32'(dec.op));
        check_field("dec.imm", 32'hFFFF_FFFC, dec.imm);
      end
      default: check_field("dec.op", 32'(iram_pkg::OP_IMM), 32'(dec.op));
    endcase
  endtask

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Checker, sampled mid-cycle
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  always @(posedge clk) edge_cnt <= edge_cnt + 32'd1;

  always @(negedge clk) begin
    logic [31:0] word;
    host_write_t w;
    if (nrst) begin
      // A write sampled at edge N is seen by responses from edge N+3 on
      while (pending.size() > 0 && pending[0].at_edge + 32'd3 <= edge_cnt) begin
        w = pending.pop_front();
        model_mem[w.addr[5:2]] = merge_bytes(model_mem[w.addr[5:2]], w.data, w.strb);
      end
      if (idle_window) check_field("dec.valid", 32'd0, 32'(dec.valid));
      if (dec.valid) begin
        word = model_mem[dec.addr[5:2]];
        check_field("dec.addr", 32'(next_addr), 32'(dec.addr));
        check_field("dec.op", 32'(ref_op(word)), 32'(dec.op));
        check_field("dec.rd", 32'(word[11:7]), 32'(dec.rd));
        check_field("dec.imm", ref_imm(word), dec.imm);
        if (resp_cnt < 16) check_boot_word();
        if (dec.op == iram_pkg::OP_OTHER) other_cnt++;
        if (word != boot_mem[dec.addr[5:2]]) patched_cnt++;
        next_addr = next_addr + 6'd4;
        resp_cnt++;
      end
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Stimulus
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  task automatic next_cycle();
    @(posedge clk);
    #2;
  endtask

  task automatic wait_responses(int unsigned count, int unsigned limit);
    int unsigned target;
    int unsigned cycles;
    target = resp_cnt + count;
    cycles = 0;
    while (resp_cnt < target) begin
      if (cycles == limit) begin
        stop_fail($sformatf("Timed out waiting for %0d responses", count));
      end else begin
        next_cycle();
        cycles++;
      end
    end
  endtask

  task automatic wait_valid_low(int unsigned limit);
    int unsigned cycles;
    cycles = 0;
    while (dec.valid) begin
      if (cycles == limit) begin
        stop_fail("Decoder output stayed valid after run was dropped");
      end else begin
        next_cycle();
        cycles++;
      end
    end
  endtask

  task automatic host_write(logic [5:0] addr, logic [3:0] strb, logic [31:0] data);
    host_write_t w;
    w.at_edge = edge_cnt + 32'd1;
    w.addr    = addr;
    w.strb    = strb;
    w.data    = data;
    pending.push_back(w);
    host_wr    = 1'b1;
    host_addr  = addr;
    host_wstrb = strb;
    host_wdata = data;
    next_cycle();
    host_wr    = 1'b0;
  endtask

  initial begin
    int unsigned cycles;
    int unsigned gap;
    logic [6:0] odd_major [4];
    void'($urandom(32'h39ff));
    run         = 1'b0;
    host_wr     = 1'b0;
    host_addr   = '0;
    host_wstrb  = '0;
    host_wdata  = '0;
    edge_cnt    = '0;
    resp_cnt    = 0;
    next_addr   = '0;
    idle_window = 1'b0;
    other_cnt   = 0;
    patched_cnt = 0;
    model_mem   = iram_pkg::reset_image();
    boot_mem    = iram_pkg::reset_image();
    odd_major   = '{7'h73, 7'h0f, 7'h33, 7'h17};

    cycles = 0;
    while (nrst !== 1'b1) begin
      if (cycles == 40) stop_fail("Reset was never released");
      else begin
        @(posedge clk);
        cycles++;
      end
    end
    #2;

    // Idle after reset
    idle_window = 1'b1;
    repeat (20) next_cycle();
    idle_window = 1'b0;

    // Boot program, then one full wrap
    run = 1'b1;
    wait_responses(16, 40);
    wait_responses(16, 40);

    // Random byte patches while running
    for (int i = 0; i < 24; i++) begin
      host_write(6'($urandom), 4'($urandom_range(1, 15)), $urandom);
      gap = $urandom_range(0, 3);
      repeat (gap) next_cycle();
    end
    wait_responses(20, 60);

    for (int i = 0; i < 4; i++) begin
      host_write({4'($urandom), 2'b00}, 4'hF, {25'($urandom), odd_major[i]});
    end
    wait_responses(20, 60);

    // Stop and resume
    run = 1'b0;
    wait_valid_low(3);
    idle_window = 1'b1;
    repeat (10) next_cycle();
    idle_window = 1'b0;
    run = 1'b1;
    wait_responses(8, 20);
    run = 1'b0;
    wait_valid_low(3);

    if (other_cnt == 0) stop_fail("No unknown opcode reached the decoder");
    else if (patched_cnt == 0) stop_fail("No patched word was fetched back");
    else begin
      $display("=== PASS ===");
      $finish;
    end
  end

endmodule

`default_nettype wire
